// ==== design/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [2:0]  alu_op_t;
    typedef logic [1:0]  fwd_sel_t;

    // Primary opcodes
    localparam opcode_t OP_RTYPE = 6'h00;
    localparam opcode_t OP_ADDI  = 6'h08;
    localparam opcode_t OP_LW    = 6'h23;
    localparam opcode_t OP_SW    = 6'h2B;
    localparam opcode_t OP_BEQ   = 6'h04;
    localparam opcode_t OP_HALT  = 6'h3F;

    // R-type function codes
    localparam funct_t FN_ADD = 6'h20;
    localparam funct_t FN_SUB = 6'h22;
    localparam funct_t FN_AND = 6'h24;
    localparam funct_t FN_OR  = 6'h25;
    localparam funct_t FN_SLT = 6'h2A;

    localparam alu_op_t ALU_ADD = 3'd0;
    localparam alu_op_t ALU_SUB = 3'd1;
    localparam alu_op_t ALU_AND = 3'd2;
    localparam alu_op_t ALU_OR  = 3'd3;
    localparam alu_op_t ALU_SLT = 3'd4;

    // Operand sources in execute
    localparam fwd_sel_t FWD_NONE  = 2'd0;
    localparam fwd_sel_t FWD_EXMEM = 2'd1;
    localparam fwd_sel_t FWD_MEMWB = 2'd2;

endpackage

`default_nettype wire

// ==== design/mips_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_control import mips_pkg::*; (
    input  wire        i_clk,
    input  wire        i_reset,
    input  word_t      i_ifid_instr,
    input  reg_addr_t  i_idex_rt,
    input  reg_addr_t  i_idex_rs,
    input  wire        i_idex_mem_read,
    input  reg_addr_t  i_exmem_rd,
    input  wire        i_exmem_reg_write,
    input  wire        i_exmem_branch,
    input  wire        i_exmem_zero,
    input  reg_addr_t  i_memwb_rd,
    input  wire        i_memwb_reg_write,
    output logic       o_stall,
    output logic       o_ifid_flush,
    output logic       o_pc_src,
    output logic       o_ex_kill,
    output fwd_sel_t   o_fwd_a,
    output fwd_sel_t   o_fwd_b,
    output logic       o_reg_write,
    output logic       o_mem_read,
    output logic       o_mem_write,
    output logic       o_mem_to_reg,
    output logic       o_alu_src,
    output logic       o_reg_dst_rd,
    output logic       o_branch,
    output logic       o_halt,
    output alu_op_t    o_alu_op
);

    opcode_t   opcode;
    funct_t    funct;
    reg_addr_t id_rs;
    reg_addr_t id_rt;
    logic      load_use;
    logic      bubble;
    logic      halt_go;
    logic      freeze;

    assign opcode = i_ifid_instr[31:26];
    assign funct  = i_ifid_instr[5:0];
    assign id_rs  = i_ifid_instr[25:21];
    assign id_rt  = i_ifid_instr[20:16];

    assign load_use = i_idex_mem_read && (i_idex_rt != 5'd0) &&
                      ((i_idex_rt == id_rs) || (i_idex_rt == id_rt));

    // Branch resolves in MEM
    assign o_pc_src  = i_exmem_branch & i_exmem_zero;
    assign o_ex_kill = o_pc_src;

    assign o_stall = (load_use | freeze) & ~o_pc_src;
    assign bubble  = o_stall | o_pc_src;
    assign halt_go = (opcode == OP_HALT) & ~bubble;

    // Instruction after the halt is dropped in the same cycle
    assign o_ifid_flush = o_pc_src | freeze | halt_go;

    always_ff @(posedge i_clk) begin
        if (i_reset || o_pc_src) begin
            freeze <= 1'b0;
        end else if (halt_go) begin
            freeze <= 1'b1;
        end
    end

    always_comb begin
        o_reg_write  = 1'b0;
        o_mem_read   = 1'b0;
        o_mem_write  = 1'b0;
        o_mem_to_reg = 1'b0;
        o_alu_src    = 1'b0;
        o_reg_dst_rd = 1'b0;
        o_branch     = 1'b0;
        o_halt       = 1'b0;
        o_alu_op     = ALU_ADD;
        if (!bubble) begin
            case (opcode)
                OP_RTYPE: begin
                    o_reg_dst_rd = 1'b1;
                    o_reg_write  = 1'b1;
                    case (funct)
                        FN_ADD:  o_alu_op = ALU_ADD;
                        FN_SUB:  o_alu_op = ALU_SUB;
                        FN_AND:  o_alu_op = ALU_AND;
                        FN_OR:   o_alu_op = ALU_OR;
                        FN_SLT:  o_alu_op = ALU_SLT;
                        default: o_reg_write = 1'b0;
                    endcase
                end
                OP_ADDI: begin
                    o_reg_write = 1'b1;
                    o_alu_src   = 1'b1;
                end
                OP_LW: begin
                    o_reg_write  = 1'b1;
                    o_mem_read   = 1'b1;
                    o_mem_to_reg = 1'b1;
                    o_alu_src    = 1'b1;
                end
                OP_SW: begin
                    o_mem_write = 1'b1;
                    o_alu_src   = 1'b1;
                end
                OP_BEQ: begin
                    o_branch = 1'b1;
                    o_alu_op = ALU_SUB;
                end
                OP_HALT: o_halt = 1'b1;
                default: ;
            endcase
        end
    end

    // EX/MEM wins over MEM/WB, r0 never forwarded
    function automatic fwd_sel_t fwd_pick(input reg_addr_t src);
        if (i_exmem_reg_write && (i_exmem_rd != 5'd0) && (i_exmem_rd == src)) begin
            return FWD_EXMEM;
        end
        if (i_memwb_reg_write && (i_memwb_rd != 5'd0) && (i_memwb_rd == src)) begin
            return FWD_MEMWB;
        end
        return FWD_NONE;
    endfunction

    assign o_fwd_a = fwd_pick(i_idex_rs);
    assign o_fwd_b = fwd_pick(i_idex_rt);

endmodule

`default_nettype wire

// ==== design/mips_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_fetch import mips_pkg::*; #(
    parameter int IMEM_WORDS = 256
) (
    input  wire        i_clk,
    input  wire        i_reset,
    input  wire        i_stall,
    input  wire        i_ifid_flush,
    input  wire        i_pc_src,
    input  word_t      i_branch_target,
    input  wire        i_imem_we,
    input  wire  [7:0] i_imem_addr,
    input  word_t      i_imem_data,
    output word_t      o_pc,
    output word_t      o_ifid_pc4,
    output word_t      o_ifid_instr
);

    localparam int IMEM_AW = $clog2(IMEM_WORDS);

    word_t imem [IMEM_WORDS];
    word_t pc4;

    assign pc4 = o_pc + 32'd4;

    always_ff @(posedge i_clk) begin
        if (i_imem_we) begin
            imem[i_imem_addr[IMEM_AW-1:0]] <= i_imem_data;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_pc <= '0;
        end else if (i_pc_src) begin
            o_pc <= i_branch_target;
        end else if (!i_stall) begin
            o_pc <= pc4;
        end
    end

    // Flush leaves an all-zero word, which decodes as a no-op
    always_ff @(posedge i_clk) begin
        if (i_reset || i_ifid_flush) begin
            o_ifid_instr <= '0;
        end else if (!i_stall) begin
            o_ifid_instr <= imem[o_pc[IMEM_AW+1:2]];
        end
        if (!i_stall) begin
            o_ifid_pc4 <= pc4;
        end
    end

endmodule

`default_nettype wire

// ==== design/mips_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_decode import mips_pkg::*; (
    input  wire        i_clk,
    input  wire        i_reset,
    input  word_t      i_ifid_pc4,
    input  word_t      i_ifid_instr,
    input  wire        i_reg_write,
    input  wire        i_mem_read,
    input  wire        i_mem_write,
    input  wire        i_mem_to_reg,
    input  wire        i_alu_src,
    input  wire        i_reg_dst_rd,
    input  wire        i_branch,
    input  wire        i_halt,
    input  alu_op_t    i_alu_op,
    input  wire        i_wb_we,
    input  reg_addr_t  i_wb_rd,
    input  word_t      i_wb_data,
    input  reg_addr_t  i_dbg_reg_addr,
    output word_t      o_dbg_reg_data,
    output word_t      o_idex_pc4,
    output word_t      o_idex_rs_data,
    output word_t      o_idex_rt_data,
    output word_t      o_idex_imm,
    output reg_addr_t  o_idex_rs,
    output reg_addr_t  o_idex_rt,
    output reg_addr_t  o_idex_rd,
    output logic       o_idex_reg_write,
    output logic       o_idex_mem_read,
    output logic       o_idex_mem_write,
    output logic       o_idex_mem_to_reg,
    output logic       o_idex_alu_src,
    output logic       o_idex_reg_dst_rd,
    output logic       o_idex_branch,
    output logic       o_idex_halt,
    output alu_op_t    o_idex_alu_op
);

    word_t regs [32];

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wb_we && (i_wb_rd != 5'd0)) begin
            regs[i_wb_rd] <= i_wb_data;
        end
    end

    // Same-cycle write reaches the reader
    function automatic word_t rd_port(input reg_addr_t addr);
        if (addr == 5'd0) begin
            return '0;
        end
        if (i_wb_we && (i_wb_rd == addr)) begin
            return i_wb_data;
        end
        return regs[addr];
    endfunction

    assign o_dbg_reg_data = rd_port(i_dbg_reg_addr);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_idex_reg_write  <= 1'b0;
            o_idex_mem_read   <= 1'b0;
            o_idex_mem_write  <= 1'b0;
            o_idex_mem_to_reg <= 1'b0;
            o_idex_alu_src    <= 1'b0;
            o_idex_reg_dst_rd <= 1'b0;
            o_idex_branch     <= 1'b0;
            o_idex_halt       <= 1'b0;
            o_idex_alu_op     <= ALU_ADD;
            o_idex_rs         <= '0;
            o_idex_rt         <= '0;
            o_idex_rd         <= '0;
        end else begin
            o_idex_reg_write  <= i_reg_write;
            o_idex_mem_read   <= i_mem_read;
            o_idex_mem_write  <= i_mem_write;
            o_idex_mem_to_reg <= i_mem_to_reg;
            o_idex_alu_src    <= i_alu_src;
            o_idex_reg_dst_rd <= i_reg_dst_rd;
            o_idex_branch     <= i_branch;
            o_idex_halt       <= i_halt;
            o_idex_alu_op     <= i_alu_op;
            o_idex_rs         <= i_ifid_instr[25:21];
            o_idex_rt         <= i_ifid_instr[20:16];
            o_idex_rd         <= i_ifid_instr[15:11];
        end
        o_idex_pc4     <= i_ifid_pc4;
        o_idex_rs_data <= rd_port(i_ifid_instr[25:21]);
        o_idex_rt_data <= rd_port(i_ifid_instr[20:16]);
        o_idex_imm     <= {{16{i_ifid_instr[15]}}, i_ifid_instr[15:0]};
    end

endmodule

`default_nettype wire

// ==== design/mips_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_execute import mips_pkg::*; (
    input  wire        i_clk,
    input  wire        i_reset,
    input  wire        i_ex_kill,
    input  word_t      i_idex_pc4,
    input  word_t      i_idex_rs_data,
    input  word_t      i_idex_rt_data,
    input  word_t      i_idex_imm,
    input  reg_addr_t  i_idex_rt,
    input  reg_addr_t  i_idex_rd,
    input  wire        i_idex_reg_write,
    input  wire        i_idex_mem_write,
    input  wire        i_idex_mem_to_reg,
    input  wire        i_idex_alu_src,
    input  wire        i_idex_reg_dst_rd,
    input  wire        i_idex_branch,
    input  wire        i_idex_halt,
    input  alu_op_t    i_idex_alu_op,
    input  fwd_sel_t   i_fwd_a,
    input  fwd_sel_t   i_fwd_b,
    input  word_t      i_wb_data,
    output word_t      o_exmem_alu,
    output word_t      o_exmem_store_data,
    output reg_addr_t  o_exmem_rd,
    output logic       o_exmem_zero,
    output word_t      o_exmem_branch_target,
    output logic       o_exmem_reg_write,
    output logic       o_exmem_mem_write,
    output logic       o_exmem_mem_to_reg,
    output logic       o_exmem_branch,
    output logic       o_exmem_halt
);

    word_t op_a;
    word_t op_b_reg;
    word_t op_b;
    word_t alu_res;

    function automatic word_t fwd_mux(input fwd_sel_t sel, input word_t reg_val);
        case (sel)
            FWD_EXMEM: return o_exmem_alu;
            FWD_MEMWB: return i_wb_data;
            default:   return reg_val;
        endcase
    endfunction

    assign op_a     = fwd_mux(i_fwd_a, i_idex_rs_data);
    assign op_b_reg = fwd_mux(i_fwd_b, i_idex_rt_data);
    assign op_b     = i_idex_alu_src ? i_idex_imm : op_b_reg;

    always_comb begin
        case (i_idex_alu_op)
            ALU_SUB: alu_res = op_a - op_b;
            ALU_AND: alu_res = op_a & op_b;
            ALU_OR:  alu_res = op_a | op_b;
            ALU_SLT: alu_res = {31'd0, $signed(op_a) < $signed(op_b)};
            default: alu_res = op_a + op_b;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_exmem_reg_write  <= 1'b0;
            o_exmem_mem_write  <= 1'b0;
            o_exmem_mem_to_reg <= 1'b0;
            o_exmem_branch     <= 1'b0;
            o_exmem_halt       <= 1'b0;
            o_exmem_rd         <= '0;
        end else begin
            // Kill squashes the instruction behind a taken branch
            o_exmem_reg_write  <= i_idex_reg_write & ~i_ex_kill;
            o_exmem_mem_write  <= i_idex_mem_write & ~i_ex_kill;
            o_exmem_mem_to_reg <= i_idex_mem_to_reg;
            o_exmem_branch     <= i_idex_branch & ~i_ex_kill;
            o_exmem_halt       <= i_idex_halt & ~i_ex_kill;
            o_exmem_rd         <= i_idex_reg_dst_rd ? i_idex_rd : i_idex_rt;
        end
        o_exmem_alu           <= alu_res;
        o_exmem_zero          <= (alu_res == '0);
        o_exmem_store_data    <= op_b_reg;
        o_exmem_branch_target <= i_idex_pc4 + {i_idex_imm[29:0], 2'b00};
    end

endmodule

`default_nettype wire

// ==== design/mips_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_memory import mips_pkg::*; #(
    parameter int DMEM_WORDS = 16
) (
    input  wire        i_clk,
    input  wire        i_reset,
    input  word_t      i_exmem_alu,
    input  word_t      i_exmem_store_data,
    input  reg_addr_t  i_exmem_rd,
    input  wire        i_exmem_reg_write,
    input  wire        i_exmem_mem_write,
    input  wire        i_exmem_mem_to_reg,
    input  wire        i_exmem_halt,
    input  word_t      i_dbg_mem_addr,
    output word_t      o_dbg_mem_data,
    output word_t      o_wb_data,
    output reg_addr_t  o_memwb_rd,
    output logic       o_memwb_reg_write,
    output logic       o_mips_halt
);

    localparam int DMEM_AW = $clog2(DMEM_WORDS);

    word_t dmem [DMEM_WORDS];
    word_t memwb_alu;
    word_t memwb_load;
    logic  memwb_mem_to_reg;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (i_exmem_mem_write) begin
            dmem[i_exmem_alu[DMEM_AW+1:2]] <= i_exmem_store_data;
        end
    end

    assign o_dbg_mem_data = dmem[i_dbg_mem_addr[DMEM_AW+1:2]];

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_memwb_reg_write <= 1'b0;
            memwb_mem_to_reg  <= 1'b0;
            o_memwb_rd        <= '0;
            o_mips_halt       <= 1'b0;
        end else begin
            o_memwb_reg_write <= i_exmem_reg_write;
            memwb_mem_to_reg  <= i_exmem_mem_to_reg;
            o_memwb_rd        <= i_exmem_rd;
            // Halt stays up until reset
            o_mips_halt       <= o_mips_halt | i_exmem_halt;
        end
        memwb_alu  <= i_exmem_alu;
        memwb_load <= dmem[i_exmem_alu[DMEM_AW+1:2]];
    end

    assign o_wb_data = memwb_mem_to_reg ? memwb_load : memwb_alu;

endmodule

`default_nettype wire

// ==== design/mips_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_top import mips_pkg::*; #(
    parameter int IMEM_WORDS = 256,
    parameter int DMEM_WORDS = 16
) (
    input  wire        i_clk,
    input  wire        i_reset,
    input  wire        i_imem_we,
    input  wire  [7:0] i_imem_addr,
    input  word_t      i_imem_data,
    input  reg_addr_t  i_dbg_reg_addr,
    output word_t      o_dbg_reg_data,
    input  word_t      i_dbg_mem_addr,
    output word_t      o_dbg_mem_data,
    output word_t      o_pc,
    output logic       o_mips_halt
);

    logic      stall, ifid_flush, pc_src, ex_kill;
    fwd_sel_t  fwd_a, fwd_b;
    logic      c_reg_write, c_mem_read, c_mem_write, c_mem_to_reg;
    logic      c_alu_src, c_reg_dst_rd, c_branch, c_halt;
    alu_op_t   c_alu_op;
    word_t     ifid_pc4, ifid_instr;
    word_t     idex_pc4, idex_rs_data, idex_rt_data, idex_imm;
    reg_addr_t idex_rs, idex_rt, idex_rd;
    logic      idex_reg_write, idex_mem_read, idex_mem_write, idex_mem_to_reg;
    logic      idex_alu_src, idex_reg_dst_rd, idex_branch, idex_halt;
    alu_op_t   idex_alu_op;
    word_t     exmem_alu, exmem_store_data, exmem_branch_target;
    reg_addr_t exmem_rd;
    logic      exmem_zero, exmem_reg_write, exmem_mem_write;
    logic      exmem_mem_to_reg, exmem_branch, exmem_halt;
    word_t     wb_data;
    reg_addr_t memwb_rd;
    logic      memwb_reg_write;

    mips_control u_control (
        .i_clk(i_clk), .i_reset(i_reset), .i_ifid_instr(ifid_instr),
        .i_idex_rt(idex_rt), .i_idex_rs(idex_rs), .i_idex_mem_read(idex_mem_read),
        .i_exmem_rd(exmem_rd), .i_exmem_reg_write(exmem_reg_write),
        .i_exmem_branch(exmem_branch), .i_exmem_zero(exmem_zero),
        .i_memwb_rd(memwb_rd), .i_memwb_reg_write(memwb_reg_write),
        .o_stall(stall), .o_ifid_flush(ifid_flush), .o_pc_src(pc_src),
        .o_ex_kill(ex_kill), .o_fwd_a(fwd_a), .o_fwd_b(fwd_b),
        .o_reg_write(c_reg_write), .o_mem_read(c_mem_read), .o_mem_write(c_mem_write),
        .o_mem_to_reg(c_mem_to_reg), .o_alu_src(c_alu_src), .o_reg_dst_rd(c_reg_dst_rd),
        .o_branch(c_branch), .o_halt(c_halt), .o_alu_op(c_alu_op)
    );

    mips_fetch #(.IMEM_WORDS(IMEM_WORDS)) u_fetch (
        .i_clk(i_clk), .i_reset(i_reset), .i_stall(stall), .i_ifid_flush(ifid_flush),
        .i_pc_src(pc_src), .i_branch_target(exmem_branch_target),
        .i_imem_we(i_imem_we), .i_imem_addr(i_imem_addr), .i_imem_data(i_imem_data),
        .o_pc(o_pc), .o_ifid_pc4(ifid_pc4), .o_ifid_instr(ifid_instr)
    );

    mips_decode u_decode (
        .i_clk(i_clk), .i_reset(i_reset), .i_ifid_pc4(ifid_pc4), .i_ifid_instr(ifid_instr),
        .i_reg_write(c_reg_write), .i_mem_read(c_mem_read), .i_mem_write(c_mem_write),
        .i_mem_to_reg(c_mem_to_reg), .i_alu_src(c_alu_src), .i_reg_dst_rd(c_reg_dst_rd),
        .i_branch(c_branch), .i_halt(c_halt), .i_alu_op(c_alu_op),
        .i_wb_we(memwb_reg_write), .i_wb_rd(memwb_rd), .i_wb_data(wb_data),
        .i_dbg_reg_addr(i_dbg_reg_addr), .o_dbg_reg_data(o_dbg_reg_data),
        .o_idex_pc4(idex_pc4), .o_idex_rs_data(idex_rs_data), .o_idex_rt_data(idex_rt_data),
        .o_idex_imm(idex_imm), .o_idex_rs(idex_rs), .o_idex_rt(idex_rt), .o_idex_rd(idex_rd),
        .o_idex_reg_write(idex_reg_write), .o_idex_mem_read(idex_mem_read),
        .o_idex_mem_write(idex_mem_write), .o_idex_mem_to_reg(idex_mem_to_reg),
        .o_idex_alu_src(idex_alu_src), .o_idex_reg_dst_rd(idex_reg_dst_rd),
        .o_idex_branch(idex_branch), .o_idex_halt(idex_halt), .o_idex_alu_op(idex_alu_op)
    );

    mips_execute u_execute (
        .i_clk(i_clk), .i_reset(i_reset), .i_ex_kill(ex_kill), .i_idex_pc4(idex_pc4),
        .i_idex_rs_data(idex_rs_data), .i_idex_rt_data(idex_rt_data), .i_idex_imm(idex_imm),
        .i_idex_rt(idex_rt), .i_idex_rd(idex_rd), .i_idex_reg_write(idex_reg_write),
        .i_idex_mem_write(idex_mem_write), .i_idex_mem_to_reg(idex_mem_to_reg),
        .i_idex_alu_src(idex_alu_src), .i_idex_reg_dst_rd(idex_reg_dst_rd),
        .i_idex_branch(idex_branch), .i_idex_halt(idex_halt), .i_idex_alu_op(idex_alu_op),
        .i_fwd_a(fwd_a), .i_fwd_b(fwd_b), .i_wb_data(wb_data),
        .o_exmem_alu(exmem_alu), .o_exmem_store_data(exmem_store_data),
        .o_exmem_rd(exmem_rd), .o_exmem_zero(exmem_zero),
        .o_exmem_branch_target(exmem_branch_target), .o_exmem_reg_write(exmem_reg_write),
        .o_exmem_mem_write(exmem_mem_write), .o_exmem_mem_to_reg(exmem_mem_to_reg),
        .o_exmem_branch(exmem_branch), .o_exmem_halt(exmem_halt)
    );

    mips_memory #(.DMEM_WORDS(DMEM_WORDS)) u_memory (
        .i_clk(i_clk), .i_reset(i_reset), .i_exmem_alu(exmem_alu),
        .i_exmem_store_data(exmem_store_data), .i_exmem_rd(exmem_rd),
        .i_exmem_reg_write(exmem_reg_write), .i_exmem_mem_write(exmem_mem_write),
        .i_exmem_mem_to_reg(exmem_mem_to_reg), .i_exmem_halt(exmem_halt),
        .i_dbg_mem_addr(i_dbg_mem_addr), .o_dbg_mem_data(o_dbg_mem_data),
        .o_wb_data(wb_data), .o_memwb_rd(memwb_rd), .o_memwb_reg_write(memwb_reg_write),
        .o_mips_halt(o_mips_halt)
    );

endmodule

`default_nettype wire

// ==== verification/mips_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_asserts import mips_pkg::*; (
    input wire       i_clk,
    input wire       i_reset,
    input wire       i_freeze,
    input wire       i_stall,
    input wire       i_pc_src,
    input word_t     i_ifid_instr,
    input wire       i_exmem_reg_write,
    input wire       i_exmem_branch,
    input fwd_sel_t  i_fwd_a,
    input reg_addr_t i_exmem_rd,
    input reg_addr_t i_memwb_rd
);

    // A bubble put into ID/EX reaches EX/MEM with no write and no branch
    a_bubble: assert property (@(posedge i_clk) disable iff (i_reset)
        $past(i_stall || i_pc_src, 2) |-> !(i_exmem_reg_write || i_exmem_branch))
        else $error("non-bubble written into ID/EX during stall or flush");

    a_fwd_r0: assert property (@(posedge i_clk) disable iff (i_reset)
        !(((i_fwd_a == FWD_EXMEM) && (i_exmem_rd == 5'd0)) ||
          ((i_fwd_a == FWD_MEMWB) && (i_memwb_rd == 5'd0))))
        else $error("operand A forwarded from register 0");

    // Frozen fetch hands only no-ops to decode
    a_freeze_flush: assert property (@(posedge i_clk) disable iff (i_reset)
        $past(i_freeze) |-> (i_ifid_instr == '0))
        else $error("IF/ID not flushed while frozen");

endmodule

bind mips_control mips_asserts u_asserts (
    .i_clk(i_clk),
    .i_reset(i_reset),
    .i_freeze(freeze),
    .i_stall(o_stall),
    .i_pc_src(o_pc_src),
    .i_ifid_instr(i_ifid_instr),
    .i_exmem_reg_write(i_exmem_reg_write),
    .i_exmem_branch(i_exmem_branch),
    .i_fwd_a(o_fwd_a),
    .i_exmem_rd(i_exmem_rd),
    .i_memwb_rd(i_memwb_rd)
);

`default_nettype wire

// ==== verification/mips_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_tb import mips_pkg::*; ();

    localparam int IMEM_WORDS      = 256;
    localparam int DMEM_WORDS      = 16;
    localparam int PROG_LEN        = 28;
    localparam int MAX_STEPS       = 1000;
    localparam int WATCHDOG_CYCLES = PROG_LEN * 40;

    logic      i_clk;
    logic      i_reset;
    logic      i_imem_we;
    logic [7:0] i_imem_addr;
    word_t     i_imem_data;
    reg_addr_t i_dbg_reg_addr;
    word_t     o_dbg_reg_data;
    word_t     i_dbg_mem_addr;
    word_t     o_dbg_mem_data;
    word_t     o_pc;
    logic      o_mips_halt;

    word_t prog [PROG_LEN];
    word_t ref_regs [32];
    word_t ref_dmem [DMEM_WORDS];
    word_t ref_halt_pc;
    word_t rng_state;

    mips_top #(
        .IMEM_WORDS(IMEM_WORDS),
        .DMEM_WORDS(DMEM_WORDS)
    ) dut (
        .i_clk(i_clk),
        .i_reset(i_reset),
        .i_imem_we(i_imem_we),
        .i_imem_addr(i_imem_addr),
        .i_imem_data(i_imem_data),
        .i_dbg_reg_addr(i_dbg_reg_addr),
        .o_dbg_reg_data(o_dbg_reg_data),
        .i_dbg_mem_addr(i_dbg_mem_addr),
        .o_dbg_mem_data(o_dbg_mem_data),
        .o_pc(o_pc),
        .o_mips_halt(o_mips_halt)
    );

    initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    function automatic word_t xorshift32(input word_t x);
        word_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [15:0] rand_imm();
        rng_state = xorshift32(rng_state);
        return rng_state[15:0];
    endfunction

    function automatic word_t enc_r(input funct_t fn, input reg_addr_t rd,
                                    input reg_addr_t rs, input reg_addr_t rt);
        return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic word_t enc_i(input opcode_t op, input reg_addr_t rt,
                                    input reg_addr_t rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic void build_program();
        rng_state = 32'd84042;
        // Dependent ALU chain
        prog[0]  = enc_i(OP_ADDI, 5'd1, 5'd0, rand_imm());
        prog[1]  = enc_i(OP_ADDI, 5'd2, 5'd1, rand_imm());
        prog[2]  = enc_r(FN_ADD, 5'd3, 5'd1, 5'd2);
        prog[3]  = enc_r(FN_SUB, 5'd4, 5'd3, 5'd1);
        prog[4]  = enc_r(FN_AND, 5'd5, 5'd4, 5'd3);
        prog[5]  = enc_r(FN_OR, 5'd6, 5'd5, 5'd2);
        prog[6]  = enc_r(FN_SLT, 5'd7, 5'd6, 5'd4);
        prog[7]  = enc_r(FN_SLT, 5'd8, 5'd4, 5'd6);
        // r0 stays zero
        prog[8]  = enc_i(OP_ADDI, 5'd0, 5'd0, rand_imm());
        prog[9]  = enc_r(FN_ADD, 5'd9, 5'd0, 5'd1);
        // Store, load and dependent use
        prog[10] = enc_i(OP_SW, 5'd3, 5'd0, 16'd4);
        prog[11] = enc_i(OP_LW, 5'd10, 5'd0, 16'd4);
        prog[12] = enc_r(FN_ADD, 5'd11, 5'd10, 5'd2);
        prog[13] = enc_i(OP_SW, 5'd6, 5'd0, 16'd8);
        // Taken branch over three instructions
        prog[14] = enc_i(OP_BEQ, 5'd1, 5'd1, 16'd3);
        prog[15] = enc_i(OP_ADDI, 5'd12, 5'd0, rand_imm());
        prog[16] = enc_i(OP_SW, 5'd1, 5'd0, 16'd12);
        prog[17] = enc_i(OP_ADDI, 5'd13, 5'd0, rand_imm());
        // Normally not taken
        prog[18] = enc_i(OP_BEQ, 5'd2, 5'd1, 16'd1);
        prog[19] = enc_i(OP_ADDI, 5'd14, 5'd0, rand_imm());
        prog[20] = enc_i(OP_SW, 5'd2, 5'd0, 16'd16);
        prog[21] = enc_r(FN_ADD, 5'd15, 5'd14, 5'd11);
        prog[22] = enc_i(OP_LW, 5'd16, 5'd0, 16'd8);
        prog[23] = enc_r(FN_SUB, 5'd17, 5'd16, 5'd7);
        prog[24] = {OP_HALT, 26'd0};
        // Must never retire
        prog[25] = enc_i(OP_ADDI, 5'd18, 5'd0, rand_imm());
        prog[26] = enc_i(OP_SW, 5'd1, 5'd0, 16'd20);
        prog[27] = enc_i(OP_ADDI, 5'd19, 5'd0, 16'd1);
    endfunction

    function automatic int dmem_index(input word_t addr);
        return int'((addr >> 2) % DMEM_WORDS);
    endfunction

    // Sequential ISA model of the program
    function automatic void run_reference();
        word_t     instr;
        word_t     imm;
        word_t     a;
        word_t     b;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
        int        pc;
        int        steps;
        logic      done;
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            ref_dmem[i] = '0;
        end
        ref_halt_pc = '0;
        pc = 0;
        steps = 0;
        done = 1'b0;
        while (!done && pc >= 0 && pc < PROG_LEN && steps < MAX_STEPS) begin
            instr = prog[pc];
            rs = instr[25:21];
            rt = instr[20:16];
            rd = instr[15:11];
            imm = {{16{instr[15]}}, instr[15:0]};
            a = ref_regs[rs];
            b = ref_regs[rt];
            pc = pc + 1;
            steps = steps + 1;
            case (opcode_t'(instr[31:26]))
                OP_RTYPE: begin
                    case (funct_t'(instr[5:0]))
                        FN_ADD:  ref_regs[rd] = a + b;
                        FN_SUB:  ref_regs[rd] = a - b;
                        FN_AND:  ref_regs[rd] = a & b;
                        FN_OR:   ref_regs[rd] = a | b;
                        FN_SLT:  ref_regs[rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: ;
                    endcase
                end
                OP_ADDI: ref_regs[rt] = a + imm;
                OP_LW:   ref_regs[rt] = ref_dmem[dmem_index(a + imm)];
                OP_SW:   ref_dmem[dmem_index(a + imm)] = b;
                OP_BEQ: begin
                    if (a == b) begin
                        pc = pc + int'($signed(imm));
                    end
                end
                OP_HALT: begin
                    done = 1'b1;
                    // Fetch stops two words past the halt
                    ref_halt_pc = word_t'((pc + 1) * 4);
                end
                default: ;
            endcase
            ref_regs[0] = '0;
        end
    endfunction

    task automatic check_value(input string name, input word_t got, input word_t expected);
        if (got !== expected) begin
            $display("error: %s = 0x%08h, expected 0x%08h", name, got, expected);
            $display("Done: errors found");
            $fatal(1, "value mismatch");
        end
    endtask

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge i_clk);
        $display("timeout: the core did not halt and finish readback in time");
        $display("Done: errors found");
        $fatal(1, "watchdog expired");
    end

    initial begin : stimulus
        i_reset        = 1'b1;
        i_imem_we      = 1'b0;
        i_imem_addr    = 8'd0;
        i_imem_data    = '0;
        i_dbg_reg_addr = '0;
        i_dbg_mem_addr = '0;
        build_program();
        run_reference();

        // Program load under reset
        for (int i = 0; i < PROG_LEN; i++) begin
            @(negedge i_clk);
            i_imem_we   = 1'b1;
            i_imem_addr = 8'(i);
            i_imem_data = prog[i];
        end
        @(negedge i_clk);
        i_imem_we = 1'b0;
        repeat (2) @(negedge i_clk);
        check_value("o_pc", o_pc, 32'd0);
        check_value("o_mips_halt", {31'd0, o_mips_halt}, 32'd0);
        i_reset = 1'b0;

        while (!o_mips_halt) begin
            @(negedge i_clk);
        end
        repeat (10) begin
            @(negedge i_clk);
            check_value("o_pc", o_pc, ref_halt_pc);
            check_value("o_mips_halt", {31'd0, o_mips_halt}, 32'd1);
        end

        for (int r = 0; r < 32; r++) begin
            @(negedge i_clk);
            i_dbg_reg_addr = 5'(r);
            #1;
            check_value($sformatf("o_dbg_reg_data[r%0d]", r), o_dbg_reg_data, ref_regs[r]);
        end
        for (int m = 0; m < DMEM_WORDS; m++) begin
            @(negedge i_clk);
            i_dbg_mem_addr = 32'(m * 4);
            #1;
            check_value($sformatf("o_dbg_mem_data[%0d]", m), o_dbg_mem_data, ref_dmem[m]);
        end

        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== mips_lite.f ====
design/mips_pkg.sv
design/mips_control.sv
design/mips_fetch.sv
design/mips_decode.sv
design/mips_execute.sv
design/mips_memory.sv
design/mips_top.sv
verification/mips_asserts.sv
verification/mips_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the mips_lite testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module mips_tb -Mdir obj_dir -f mips_lite.f
if [ $? -ne 0 ]; then
    echo "run_sim: Verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/Vmips_tb 2>&1)
sim_status=$?
printf '%s\n' "$sim_output"

if [ $sim_status -ne 0 ]; then
    echo "run_sim: simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_output" | grep -qx "Done: no errors"; then
    exit 0
fi
echo "run_sim: pass message not found"
exit 1
